// File: dv/tb_axi_slave.sv
`timescale 1ns/1ps
`include "trace_backend_config.svh"

module tb_axi_slave (
    input  logic                             host_clk,
    input  logic                             rst,
    input  logic                             aw_stall,
    input  logic                             w_stall,
    input  logic                             err_inject,
    input  logic [`TB_AXI_ADDR_WIDTH-1:0]    awaddr,
    input  logic                             awvalid,
    output logic                             awready,
    input  logic [`TB_AXI_DATA_WIDTH-1:0]    wdata,
    input  logic                             wlast,
    input  logic                             wvalid,
    output logic                             wready,
    output logic [`TB_AXI_ID_WIDTH-1:0]      bid,
    output logic [1:0]                       bresp,
    output logic                             bvalid,
    input  logic                             bready
);
    localparam int MEM_WORDS = 4096;  // 32 KB, indexed by address bits 14..3.

    logic [`TB_AXI_DATA_WIDTH-1:0] mem [MEM_WORDS];
    logic [11:0]                   widx;

    assign awready = !aw_stall;
    assign wready  = !w_stall;
    assign bid     = '0;

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = {16'hbad0, 16'(i), ~16'(i), 16'(i)};  // Distinct per word.
        end
    end

    always @(posedge host_clk) begin
        if (rst) begin
            bvalid <= 1'b0;
            bresp  <= 2'b00;
        end else begin
            if (awvalid && awready) begin
                widx <= awaddr[14:3];
            end
            if (wvalid && wready) begin
                mem[widx] <= wdata;
                widx      <= widx + 1'b1;
                if (wlast) begin
                    bvalid <= 1'b1;
                    bresp  <= err_inject ? 2'b10 : 2'b00;  // SLVERR on request.
                end
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

endmodule

// File: dv/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic host_clk
);
    localparam real HALF_PERIOD = 2.0;  // 4 ns period.

    initial begin
        host_clk = 1'b0;
        forever #HALF_PERIOD host_clk = ~host_clk;
    end

endmodule

// File: dv/tb_trace_backend.sv
`timescale 1ns/1ps
`include "trace_backend_config.svh"

module tb_trace_backend;
    import trace_backend_pkg::*;

    localparam int T2_CYCLES   = 300;
    localparam int T3_CYCLES   = 120;
    localparam int T4_CYCLES   = 300;
    localparam int T6_CYCLES   = 8;
    localparam int STIM_CYCLES = T2_CYCLES + T3_CYCLES + T4_CYCLES + T6_CYCLES + 1;
    localparam int TIMEOUT     = 4 * STIM_CYCLES + 2000;

    logic                            host_clk;
    logic                            rst;
    tick_t                           tick_cnt = '0;
    logic                            trace0_valid, trace1_valid, trace_ready;
    trace_word_t                     trace0_data, trace1_data;
    logic                            ctrl_wen, ctrl_ren;
    ctrl_addr_t                      ctrl_waddr, ctrl_raddr;
    logic [31:0]                     ctrl_wdata, ctrl_rdata;
    logic [`TB_AXI_ID_WIDTH-1:0]     m_axi_awid, m_axi_bid, m_axi_arid, m_axi_rid;
    axi_addr_t                       m_axi_awaddr, m_axi_araddr;
    axi_data_t                       m_axi_wdata, m_axi_rdata;
    logic [`TB_AXI_DATA_WIDTH/8-1:0] m_axi_wstrb;
    logic [7:0]                      m_axi_awlen, m_axi_arlen;
    logic [2:0]                      m_axi_awsize, m_axi_arsize, m_axi_awprot, m_axi_arprot;
    logic [1:0]                      m_axi_awburst, m_axi_arburst, m_axi_bresp, m_axi_rresp;
    logic [3:0]                      m_axi_awcache, m_axi_arcache, m_axi_awqos, m_axi_arqos;
    logic [3:0]                      m_axi_awregion, m_axi_arregion;
    logic                            m_axi_awlock, m_axi_awvalid, m_axi_awready, m_axi_wlast;
    logic                            m_axi_wvalid, m_axi_wready, m_axi_bvalid, m_axi_bready;
    logic                            m_axi_arlock, m_axi_arvalid, m_axi_arready;
    logic                            m_axi_rlast, m_axi_rvalid, m_axi_rready;
    logic                            aw_stall, w_stall, err_inject;

    logic [31:0]  lfsr = 32'd2229;
    trace_word_t  exp_words [$];  // Expected stream of 32-bit record words.
    int           errors, test_errs, tests_run, tests_ok, ready_low, cycle_cnt;
    logic [7:0]   burst_len;
    int           beat_idx;

    tb_clock_gen u_clock (.host_clk(host_clk));

    trace_backend UUT (.*);

    tb_axi_slave u_slave (
        .host_clk(host_clk), .rst(rst), .aw_stall(aw_stall), .w_stall(w_stall),
        .err_inject(err_inject), .awaddr(m_axi_awaddr), .awvalid(m_axi_awvalid),
        .awready(m_axi_awready), .wdata(m_axi_wdata), .wlast(m_axi_wlast),
        .wvalid(m_axi_wvalid), .wready(m_axi_wready), .bid(m_axi_bid),
        .bresp(m_axi_bresp), .bvalid(m_axi_bvalid), .bready(m_axi_bready)
    );

    always begin
        @(posedge host_clk);
        #1;
        tick_cnt <= tick_cnt + 1'b1;
    end

    always @(posedge host_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            $display("Timeout: the run did not complete within %0d cycles", TIMEOUT);
            $display("test failed");
            $finish;
        end
    end

    // Burst attributes and the unused read channel.
    always @(posedge host_clk) begin
        if (!rst) begin
            assert (!m_axi_arvalid && !m_axi_rready) else begin
                $display("[FAIL] %0t ns: read channel active, arvalid %b rready %b",
                         $time, m_axi_arvalid, m_axi_rready);
                errors++;
            end
            if (m_axi_awvalid && m_axi_awready) begin
                burst_len <= m_axi_awlen;
                beat_idx  <= 0;
                assert (m_axi_awid == '0 && m_axi_awsize == 3'd3 && m_axi_awburst == 2'b01
                        && m_axi_awlen < `TB_BURST_LEN
                        && !$isunknown({m_axi_awlock, m_axi_awcache, m_axi_awprot,
                                        m_axi_awqos, m_axi_awregion})) else begin
                    $display("[FAIL] %0t ns: AW id %h len %0d size %0d burst %0d",
                             $time, m_axi_awid, m_axi_awlen, m_axi_awsize, m_axi_awburst);
                    errors++;
                end
            end
            if (m_axi_wvalid && m_axi_wready) begin
                beat_idx <= beat_idx + 1;
                assert (m_axi_wstrb === '1 && m_axi_wlast === (beat_idx == burst_len)) else begin
                    $display("[FAIL] %0t ns: beat %0d of awlen %0d has wstrb %h wlast %b",
                             $time, beat_idx, burst_len, m_axi_wstrb, m_axi_wlast);
                    errors++;
                end
            end
        end
    end

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
        end
        return r;
    endfunction

    task automatic expect_eq(logic [63:0] got, logic [63:0] exp, string what);
        assert (got === exp) else begin
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic reg_write(ctrl_addr_t addr, logic [31:0] data);
        @(posedge host_clk);
        #1;
        ctrl_wen   = 1'b1;
        ctrl_waddr = addr;
        ctrl_wdata = data;
        @(posedge host_clk);
        #1;
        ctrl_wen = 1'b0;
    endtask

    task automatic reg_read(ctrl_addr_t addr, output logic [31:0] data);
        @(posedge host_clk);
        #1;
        ctrl_ren   = 1'b1;
        ctrl_raddr = addr;
        @(posedge host_clk);
        #1;
        ctrl_ren = 1'b0;
        data     = ctrl_rdata;
    endtask

    task automatic apply_reset();
        @(posedge host_clk);
        #1;
        rst = 1'b1;
        repeat (5) @(posedge host_clk);
        #1;
        rst = 1'b0;
        exp_words.delete();
        ready_low = 0;
    endtask

    task automatic setup_ring(logic [31:0] base, logic [31:0] size, logic en);
        reg_write(`TB_REG_BASE_LO, base);
        reg_write(`TB_REG_BASE_HI, 32'h0);
        reg_write(`TB_REG_SIZE, size);
        reg_write(`TB_REG_CTRL, {31'h0, en});
    endtask

    // Called 1 ns after the edge when trace_ready has already settled.
    task automatic drive_traces(logic v0, logic v1, trace_word_t d0, trace_word_t d1);
        trace0_valid = v0;
        trace1_valid = v1;
        trace0_data  = d0;
        trace1_data  = d1;
        #1;
        if (!trace_ready) begin
            ready_low++;
        end else if (v0 || v1) begin
            exp_words.push_back({tick_cnt[29:0], v1, v0});  // Header.
            if (v0) exp_words.push_back(d0);
            if (v1) exp_words.push_back(d1);
        end
    endtask

    task automatic run_random(int cycles, bit stalls);
        for (int i = 0; i < cycles; i++) begin
            @(posedge host_clk);
            #1;
            aw_stall = stalls && rand_bits(1);
            w_stall  = stalls && rand_bits(1);
            drive_traces(rand_bits(1), rand_bits(1), rand_bits(32), rand_bits(32));
        end
    endtask

    task automatic idle_inputs();
        @(posedge host_clk);
        #1;
        trace0_valid = 1'b0;
        trace1_valid = 1'b0;
        aw_stall     = 1'b0;
        w_stall      = 1'b0;
    endtask

    task automatic drain_and_flush();
        logic [31:0] rd;
        idle_inputs();
        while (UUT.rec_valid) begin
            @(posedge host_clk);
            #1;
        end
        reg_write(`TB_REG_CTRL, 32'h3);
        rd = 32'h2;
        while (rd[1]) begin
            reg_read(`TB_REG_CTRL, rd);  // Flush request clears once all is written.
        end
    endtask

    task automatic check_stream(int base, int size_bytes, string tag);
        logic [63:0] exp64 [$];
        trace_word_t hi;
        logic [31:0] rd;
        int          n;
        int          ring;
        int          first;
        for (int i = 0; i < exp_words.size(); i += 2) begin
            hi = (i + 1 < exp_words.size()) ? exp_words[i + 1] : 32'h0;
            exp64.push_back({hi, exp_words[i]});
        end
        n     = exp64.size();
        ring  = size_bytes / 8;
        first = (n > ring) ? n - ring : 0;  // Older words are overwritten.
        for (int i = first; i < n; i++) begin
            expect_eq(u_slave.mem[base / 8 + i % ring], exp64[i],
                      $sformatf("%s word %0d", tag, i));
        end
        reg_read(`TB_REG_WCOUNT, rd);
        expect_eq(rd, 8 * n, {tag, " WCOUNT"});
    endtask

    task automatic end_test(int num, string name);
        tests_run++;
        if (errors == test_errs) tests_ok++;
        $display("Test %0d %s: %s", num, name, (errors == test_errs) ? "ok" : "errors");
        test_errs = errors;
    endtask

    initial begin
        logic [31:0] rd;
        rst           = 1'b1;
        trace0_valid  = 1'b0;
        trace1_valid  = 1'b0;
        trace0_data   = '0;
        trace1_data   = '0;
        ctrl_wen      = 1'b0;
        ctrl_ren      = 1'b0;
        ctrl_waddr    = '0;
        ctrl_raddr    = '0;
        ctrl_wdata    = '0;
        m_axi_arready = 1'b0;
        m_axi_rid     = '0;
        m_axi_rdata   = '0;
        m_axi_rresp   = 2'b00;
        m_axi_rlast   = 1'b0;
        m_axi_rvalid  = 1'b0;
        aw_stall      = 1'b0;
        w_stall       = 1'b0;
        err_inject    = 1'b0;

        apply_reset();
        reg_read(`TB_REG_CTRL, rd);
        expect_eq(rd, 0, "CTRL after reset");
        reg_read(`TB_REG_WCOUNT, rd);
        expect_eq(rd, 0, "WCOUNT after reset");
        reg_read(`TB_REG_STATUS, rd);
        expect_eq(rd, 0, "STATUS after reset");
        reg_write(`TB_REG_BASE_LO, 32'h1234_5678);
        reg_write(`TB_REG_BASE_HI, 32'hA);
        reg_write(`TB_REG_SIZE, 32'h100);
        reg_read(`TB_REG_BASE_LO, rd);
        expect_eq(rd, 32'h1234_5678, "BASE_LO");
        reg_read(`TB_REG_BASE_HI, rd);
        expect_eq(rd, 32'hA, "BASE_HI");
        reg_read(`TB_REG_SIZE, rd);
        expect_eq(rd, 32'h100, "SIZE");
        end_test(1, "registers");

        apply_reset();
        setup_ring(32'h1000, 32'h1000, 1'b1);
        run_random(T2_CYCLES, 1'b0);
        drain_and_flush();
        check_stream(32'h1000, 32'h1000, "stream");
        end_test(2, "random traces");

        apply_reset();
        setup_ring(32'h2000, 256, 1'b1);
        run_random(T3_CYCLES, 1'b0);
        drain_and_flush();
        check_stream(32'h2000, 256, "wrap");
        reg_read(`TB_REG_STATUS, rd);
        expect_eq(rd[2], 1'b1, "STATUS wrap bit");
        end_test(3, "ring wrap");

        apply_reset();
        setup_ring(32'h3000, 32'h1000, 1'b1);
        run_random(T4_CYCLES, 1'b1);
        assert (ready_low > 0) else begin
            $display("trace_ready never dropped while the AXI slave was stalling");
            errors++;
        end
        drain_and_flush();
        check_stream(32'h3000, 32'h1000, "stalled");
        end_test(4, "back-pressure");

        apply_reset();
        setup_ring(32'h5000, 256, 1'b1);
        @(posedge host_clk);
        #1;
        drive_traces(1'b1, 1'b1, 32'hCAFE_0001, 32'hCAFE_0002);  // Three words.
        drain_and_flush();
        check_stream(32'h5000, 256, "odd");
        expect_eq(u_slave.mem[32'h5000 / 8 + 1][63:32], 32'h0, "odd tail upper half");
        end_test(5, "odd flush");

        apply_reset();
        setup_ring(32'h6000, 32'h1000, 1'b0);
        err_inject = 1'b1;
        for (int i = 0; i < T6_CYCLES; i++) begin
            @(posedge host_clk);
            #1;
            drive_traces(1'b1, 1'b1, rand_bits(32), rand_bits(32));
        end
        idle_inputs();
        reg_write(`TB_REG_CTRL, 32'h1);
        do begin
            @(posedge host_clk);
            #1;
        end while (!(m_axi_bvalid && m_axi_bready));
        @(posedge host_clk);
        #1;
        err_inject = 1'b0;  // Only the first burst gets SLVERR.
        drain_and_flush();
        check_stream(32'h6000, 32'h1000, "slverr");
        reg_read(`TB_REG_STATUS, rd);
        expect_eq(rd[1], 1'b1, "STATUS error bit");
        reg_write(`TB_REG_STATUS, 32'h0);
        reg_read(`TB_REG_STATUS, rd);
        expect_eq(rd[1], 1'b0, "STATUS error bit after clear");
        end_test(6, "write error");

        $display("Summary: %0d tests run, %0d ok, %0d check failures",
                 tests_run, tests_ok, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: trace_backend.f
+incdir+verilog
verilog/trace_backend_pkg.sv
verilog/trace_batch.sv
verilog/fifo_trans.sv
verilog/axi_write_ctrl.sv
verilog/trace_backend.sv
dv/tb_clock_gen.sv
dv/tb_axi_slave.sv
dv/tb_trace_backend.sv

// File: verilog/axi_write_ctrl.sv
`timescale 1ns/1ps
`include "trace_backend_config.svh"

module axi_write_ctrl (
    input  logic                                host_clk,
    input  logic                                rst,
    input  logic                                ctrl_wen,
    input  trace_backend_pkg::ctrl_addr_t       ctrl_waddr,
    input  logic [31:0]                         ctrl_wdata,
    input  logic                                ctrl_ren,
    input  trace_backend_pkg::ctrl_addr_t       ctrl_raddr,
    output logic [31:0]                         ctrl_rdata,
    input  logic                                word_valid,
    input  trace_backend_pkg::axi_data_t        word_data,
    output logic                                word_ready,
    input  logic [$clog2(`TB_FIFO_DEPTH):0]     word_count,
    output logic                                flush,
    output logic [`TB_AXI_ID_WIDTH-1:0]         m_axi_awid,
    output trace_backend_pkg::axi_addr_t        m_axi_awaddr,
    output logic [7:0]                          m_axi_awlen,
    output logic [2:0]                          m_axi_awsize,
    output logic [1:0]                          m_axi_awburst,
    output logic                                m_axi_awlock,
    output logic [3:0]                          m_axi_awcache,
    output logic [2:0]                          m_axi_awprot,
    output logic [3:0]                          m_axi_awqos,
    output logic [3:0]                          m_axi_awregion,
    output logic                                m_axi_awvalid,
    input  logic                                m_axi_awready,
    output trace_backend_pkg::axi_data_t        m_axi_wdata,
    output logic [`TB_AXI_DATA_WIDTH/8-1:0]     m_axi_wstrb,
    output logic                                m_axi_wlast,
    output logic                                m_axi_wvalid,
    input  logic                                m_axi_wready,
    input  logic [`TB_AXI_ID_WIDTH-1:0]         m_axi_bid,
    input  logic [1:0]                          m_axi_bresp,
    input  logic                                m_axi_bvalid,
    output logic                                m_axi_bready
);
    import trace_backend_pkg::*;

    localparam int BEAT_BYTES = `TB_AXI_DATA_WIDTH / 8;

    wr_state_t   state;
    axi_addr_t   base;
    logic [31:0] size;
    logic [31:0] offset;
    logic [31:0] wcount;
    logic        enable;
    logic        flush_req;
    logic        bus_err;
    logic        wrapped;
    logic [7:0]  beats;
    logic [7:0]  beat_cnt;
    logic [31:0] to_wrap;
    logic [31:0] avail;
    logic [31:0] next_beats;
    logic [31:0] next_offset;
    logic        start;

    // Burst length is capped by the words buffered and the distance to the wrap point.
    assign to_wrap     = (size - offset) >> $clog2(BEAT_BYTES);
    assign avail       = (word_count >= `TB_BURST_LEN) ? `TB_BURST_LEN : 32'(word_count);
    assign next_beats  = (avail < to_wrap) ? avail : to_wrap;
    assign next_offset = offset + 32'(beats) * BEAT_BYTES;
    assign start       = enable && next_beats != '0
                         && (word_count >= `TB_BURST_LEN || flush_req);

    assign m_axi_awid     = '0;
    assign m_axi_awlen    = beats - 8'd1;
    assign m_axi_awsize   = 3'($clog2(BEAT_BYTES));
    assign m_axi_awburst  = 2'b01;              // INCR.
    assign m_axi_awlock   = 1'b0;
    assign m_axi_awcache  = 4'b0011;
    assign m_axi_awprot   = 3'b000;
    assign m_axi_awqos    = 4'h0;
    assign m_axi_awregion = 4'h0;
    assign m_axi_awvalid  = state == ADDR;
    assign m_axi_wdata    = word_data;
    assign m_axi_wstrb    = '1;
    assign m_axi_wlast    = beat_cnt == beats - 8'd1;
    assign m_axi_wvalid   = state == DATA && word_valid;
    assign word_ready     = state == DATA && m_axi_wready;
    assign m_axi_bready   = state == RESP;

    always_ff @(posedge host_clk) begin
        if (rst) begin
            state     <= IDLE;
            enable    <= 1'b0;
            flush_req <= 1'b0;
            flush     <= 1'b0;
            base      <= '0;
            size      <= '0;
            offset    <= '0;
            wcount    <= '0;
            bus_err   <= 1'b0;
            wrapped   <= 1'b0;
        end else begin
            flush <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= ADDR;
                    end else if (flush_req && !flush && word_count == '0) begin
                        flush_req <= 1'b0;  // Drained.
                    end
                end
                ADDR: begin
                    if (m_axi_awready) begin
                        state <= DATA;
                    end
                end
                DATA: begin
                    if (m_axi_wvalid && m_axi_wready && m_axi_wlast) begin
                        state <= RESP;
                    end
                end
                RESP: begin
                    if (m_axi_bvalid) begin
                        state  <= IDLE;
                        wcount <= wcount + 32'(beats) * BEAT_BYTES;
                        if (m_axi_bresp != 2'b00 || m_axi_bid != m_axi_awid) begin
                            bus_err <= 1'b1;
                        end
                        if (next_offset >= size) begin
                            offset  <= '0;
                            wrapped <= 1'b1;
                        end else begin
                            offset <= next_offset;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
            if (ctrl_wen) begin
                case (ctrl_waddr)
                    `TB_REG_CTRL: begin
                        enable <= ctrl_wdata[0];
                        if (ctrl_wdata[1]) begin
                            flush_req <= 1'b1;
                            flush     <= 1'b1;  // One pulse pushes the waiting half word.
                        end
                    end
                    `TB_REG_BASE_LO: begin
                        base[31:0] <= ctrl_wdata;
                        offset     <= '0;
                    end
                    `TB_REG_BASE_HI: base[`TB_AXI_ADDR_WIDTH-1:32] <=
                        ctrl_wdata[`TB_AXI_ADDR_WIDTH-33:0];
                    `TB_REG_SIZE: begin
                        size   <= ctrl_wdata;
                        offset <= '0;
                    end
                    `TB_REG_WCOUNT: wcount <= '0;
                    `TB_REG_STATUS: bus_err <= 1'b0;
                    default: ;
                endcase
            end
        end
    end

    // Burst fields are loaded every idle cycle and held through the burst.
    always_ff @(posedge host_clk) begin
        if (state == IDLE) begin
            beats        <= 8'(next_beats);
            beat_cnt     <= '0;
            m_axi_awaddr <= base + axi_addr_t'(offset);
        end else if (m_axi_wvalid && m_axi_wready) begin
            beat_cnt <= beat_cnt + 8'd1;
        end
    end

    always_ff @(posedge host_clk) begin
        if (ctrl_ren) begin
            case (ctrl_raddr)
                `TB_REG_CTRL:    ctrl_rdata <= {30'h0, flush_req, enable};
                `TB_REG_BASE_LO: ctrl_rdata <= base[31:0];
                `TB_REG_BASE_HI: ctrl_rdata <= 32'(base[`TB_AXI_ADDR_WIDTH-1:32]);
                `TB_REG_SIZE:    ctrl_rdata <= size;
                `TB_REG_WCOUNT:  ctrl_rdata <= wcount;
                `TB_REG_STATUS:  ctrl_rdata <= {29'h0, wrapped, bus_err, state != IDLE};
                default:         ctrl_rdata <= '0;
            endcase
        end
    end

endmodule

// File: verilog/fifo_trans.sv
`timescale 1ns/1ps
`include "trace_backend_config.svh"

module fifo_trans (
    input  logic                                host_clk,
    input  logic                                rst,
    input  logic                                rec_valid,
    input  trace_backend_pkg::record_t          rec_data,
    input  trace_backend_pkg::rec_len_t         rec_len,
    output logic                                rec_ready,
    input  logic                                flush,
    output logic                                word_valid,
    output trace_backend_pkg::axi_data_t        word_data,
    input  logic                                word_ready,
    output logic [$clog2(`TB_FIFO_DEPTH):0]     word_count
);
    import trace_backend_pkg::*;

    localparam int PTR_W = $clog2(`TB_FIFO_DEPTH);

    axi_data_t          mem [`TB_FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic               half_valid;
    trace_word_t        half_data;
    logic               rec_fire;
    logic               pop;
    logic [2:0]         total;
    logic [1:0]         push_cnt;
    logic [127:0]       cat;
    trace_word_t        words [4];

    // A record can add two pairs, so keep two slots in hand.
    assign rec_ready  = (`TB_FIFO_DEPTH - word_count) >= 2;
    assign rec_fire   = rec_valid && rec_ready;
    assign word_valid = word_count != '0;
    assign word_data  = mem[rd_ptr];
    assign pop        = word_valid && word_ready;

    always_comb begin
        total = {2'b00, half_valid} + (rec_fire ? {1'b0, rec_len} : 3'd0);
        cat   = half_valid ? {rec_data, half_data} : {32'h0, rec_data};
        for (int i = 0; i < 4; i++) begin
            words[i] = (i < total) ? cat[32*i +: 32] : '0;  // Zero past the last word.
        end
        // Flush rounds up, the odd word going out with a zero upper half.
        push_cnt = flush ? 2'((total + 3'd1) >> 1) : total[2:1];
    end

    always_ff @(posedge host_clk) begin
        if (rst) begin
            half_valid <= 1'b0;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            word_count <= '0;
        end else begin
            half_valid <= !flush && total[0];
            wr_ptr     <= wr_ptr + PTR_W'(push_cnt);
            rd_ptr     <= rd_ptr + PTR_W'(pop);
            word_count <= word_count + push_cnt - pop;
        end
    end

    always_ff @(posedge host_clk) begin
        if (total[0]) begin
            half_data <= total[1] ? words[2] : words[0];  // Odd word waits for its partner.
        end
        if (push_cnt != 2'd0) begin
            mem[wr_ptr] <= {words[1], words[0]};
        end
        if (push_cnt == 2'd2) begin
            mem[wr_ptr + 1'b1] <= {words[3], words[2]};
        end
    end

endmodule

// File: verilog/trace_backend.sv
`timescale 1ns/1ps
`include "trace_backend_config.svh"

module trace_backend (
    input  logic                                host_clk,
    input  logic                                rst,
    input  trace_backend_pkg::tick_t            tick_cnt,
    input  logic                                trace0_valid,
    input  trace_backend_pkg::trace_word_t      trace0_data,
    input  logic                                trace1_valid,
    input  trace_backend_pkg::trace_word_t      trace1_data,
    output logic                                trace_ready,
    input  logic                                ctrl_wen,
    input  trace_backend_pkg::ctrl_addr_t       ctrl_waddr,
    input  logic [31:0]                         ctrl_wdata,
    input  logic                                ctrl_ren,
    input  trace_backend_pkg::ctrl_addr_t       ctrl_raddr,
    output logic [31:0]                         ctrl_rdata,
    output logic [`TB_AXI_ID_WIDTH-1:0]         m_axi_awid,
    output trace_backend_pkg::axi_addr_t        m_axi_awaddr,
    output logic [7:0]                          m_axi_awlen,
    output logic [2:0]                          m_axi_awsize,
    output logic [1:0]                          m_axi_awburst,
    output logic                                m_axi_awlock,
    output logic [3:0]                          m_axi_awcache,
    output logic [2:0]                          m_axi_awprot,
    output logic [3:0]                          m_axi_awqos,
    output logic [3:0]                          m_axi_awregion,
    output logic                                m_axi_awvalid,
    input  logic                                m_axi_awready,
    output trace_backend_pkg::axi_data_t        m_axi_wdata,
    output logic [`TB_AXI_DATA_WIDTH/8-1:0]     m_axi_wstrb,
    output logic                                m_axi_wlast,
    output logic                                m_axi_wvalid,
    input  logic                                m_axi_wready,
    input  logic [`TB_AXI_ID_WIDTH-1:0]         m_axi_bid,
    input  logic [1:0]                          m_axi_bresp,
    input  logic                                m_axi_bvalid,
    output logic                                m_axi_bready,
    output logic [`TB_AXI_ID_WIDTH-1:0]         m_axi_arid,
    output trace_backend_pkg::axi_addr_t        m_axi_araddr,
    output logic [7:0]                          m_axi_arlen,
    output logic [2:0]                          m_axi_arsize,
    output logic [1:0]                          m_axi_arburst,
    output logic                                m_axi_arlock,
    output logic [3:0]                          m_axi_arcache,
    output logic [2:0]                          m_axi_arprot,
    output logic [3:0]                          m_axi_arqos,
    output logic [3:0]                          m_axi_arregion,
    output logic                                m_axi_arvalid,
    input  logic                                m_axi_arready,
    input  logic [`TB_AXI_ID_WIDTH-1:0]         m_axi_rid,
    input  trace_backend_pkg::axi_data_t        m_axi_rdata,
    input  logic [1:0]                          m_axi_rresp,
    input  logic                                m_axi_rlast,
    input  logic                                m_axi_rvalid,
    output logic                                m_axi_rready
);
    import trace_backend_pkg::*;

    logic                               rec_valid;
    record_t                            rec_data;
    rec_len_t                           rec_len;
    logic                               rec_ready;
    logic                               word_valid;
    axi_data_t                          word_data;
    logic                               word_ready;
    logic [$clog2(`TB_FIFO_DEPTH):0]    word_count;
    logic                               flush;

    trace_batch u_trace_batch (.*);

    fifo_trans u_fifo_trans (.*);

    axi_write_ctrl u_axi_write_ctrl (.*);

    // Write-only master.
    assign m_axi_arid     = '0;
    assign m_axi_araddr   = '0;
    assign m_axi_arlen    = 8'd0;
    assign m_axi_arsize   = 3'd0;
    assign m_axi_arburst  = 2'b01;
    assign m_axi_arlock   = 1'b0;
    assign m_axi_arcache  = 4'h0;
    assign m_axi_arprot   = 3'h0;
    assign m_axi_arqos    = 4'h0;
    assign m_axi_arregion = 4'h0;
    assign m_axi_arvalid  = 1'b0;
    assign m_axi_rready   = 1'b0;

endmodule

// File: verilog/trace_backend_config.svh
`ifndef TRACE_BACKEND_CONFIG_SVH
`define TRACE_BACKEND_CONFIG_SVH

// Bus widths.
`define TB_CTRL_ADDR_WIDTH 16
`define TB_AXI_ADDR_WIDTH  36
`define TB_AXI_DATA_WIDTH  64
`define TB_AXI_ID_WIDTH    4

// Burst and buffering.
`define TB_BURST_LEN       4
`define TB_FIFO_DEPTH      16

// Byte offsets on the control port.
`define TB_REG_CTRL        16'h0000
`define TB_REG_BASE_LO     16'h0004
`define TB_REG_BASE_HI     16'h0008
`define TB_REG_SIZE        16'h000C
`define TB_REG_WCOUNT      16'h0010
`define TB_REG_STATUS      16'h0014

`endif

// File: verilog/trace_backend_pkg.sv
`include "trace_backend_config.svh"

package trace_backend_pkg;

    typedef logic [63:0] tick_t;
    typedef logic [31:0] trace_word_t;
    typedef logic [95:0] record_t;      // Word 0 in the low bits.
    typedef logic [1:0]  rec_len_t;     // Length in words, 1 to 3.

    typedef logic [`TB_AXI_ADDR_WIDTH-1:0]  axi_addr_t;
    typedef logic [`TB_AXI_DATA_WIDTH-1:0]  axi_data_t;
    typedef logic [`TB_CTRL_ADDR_WIDTH-1:0] ctrl_addr_t;

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA,
        RESP
    } wr_state_t;

endpackage

// File: verilog/trace_batch.sv
`timescale 1ns/1ps

module trace_batch (
    input  logic                            host_clk,
    input  logic                            rst,
    input  trace_backend_pkg::tick_t        tick_cnt,
    input  logic                            trace0_valid,
    input  trace_backend_pkg::trace_word_t  trace0_data,
    input  logic                            trace1_valid,
    input  trace_backend_pkg::trace_word_t  trace1_data,
    output logic                            trace_ready,
    output logic                            rec_valid,
    output trace_backend_pkg::record_t      rec_data,
    output trace_backend_pkg::rec_len_t     rec_len,
    input  logic                            rec_ready
);
    import trace_backend_pkg::*;

    logic        capture;
    trace_word_t header;
    trace_word_t word1;
    trace_word_t word2;

    // Output register is free when empty or being taken this cycle.
    assign trace_ready = !rec_valid || rec_ready;
    assign capture     = trace_ready && (trace0_valid || trace1_valid);

    assign header = {tick_cnt[29:0], trace1_valid, trace0_valid};
    assign word1  = trace0_valid ? trace0_data : trace1_data;  // First valid channel.
    assign word2  = (trace0_valid && trace1_valid) ? trace1_data : '0;

    always_ff @(posedge host_clk) begin
        if (rst) begin
            rec_valid <= 1'b0;
        end else if (capture) begin
            rec_valid <= 1'b1;
        end else if (rec_ready) begin
            rec_valid <= 1'b0;
        end
    end

    always_ff @(posedge host_clk) begin
        if (capture) begin
            rec_data <= {word2, word1, header};
            rec_len  <= (trace0_valid && trace1_valid) ? 2'd3 : 2'd2;
        end
    end

endmodule
